// File: slide_engine.sv
// Slide engine
// Idle/run FSM that takes operand beats in order and moves their
// bytes by the slide offset into result beats with byte enables
`timescale 1ns/1ps

module slide_engine (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Issue instruction
  input  logic                 issue_valid_i,
  input  slide_pkg::slide_op_e issue_op_i,
  input  slide_pkg::sew_e      issue_sew_i,
  input  slide_pkg::byte_cnt_t issue_len_i,
  input  slide_pkg::byte_cnt_t issue_offset_i,
  input  slide_pkg::vreg_t     issue_vd_i,
  input  slide_pkg::insn_id_t  issue_id_i,
  output logic                 issue_done_o,
  // Operand beats from the lanes
  input  slide_pkg::beat_u     operand_i,
  input  logic                 operand_valid_i,
  output logic                 operand_ready_o,
  // Result queue write port
  input  logic                 rq_full_i,
  output logic                 rq_write_o,
  output slide_pkg::beat_u     rq_beat_o,
  output slide_pkg::beat_be_t  rq_be_o,
  output slide_pkg::vaddr_t    rq_addr_o,
  output slide_pkg::insn_id_t  rq_id_o,
  output logic                 rq_last_o
);

  typedef enum logic {
    st_idle,
    st_run
  } state_e;

  state_e state_q, state_d;

  // Byte pointers into the operand and the result beat
  slide_pkg::byte_cnt_t in_pnt_q, in_pnt_d;
  slide_pkg::byte_cnt_t out_pnt_q, out_pnt_d;
  // Bytes still to copy
  slide_pkg::byte_cnt_t cnt_q, cnt_d;
  slide_pkg::vaddr_t    vrf_pnt_q, vrf_pnt_d;

  // Partly filled result beat
  slide_pkg::beat_u     acc_q, acc_d;
  slide_pkg::beat_be_t  acc_be_q, acc_be_d;

  slide_pkg::beat_u     shifted;
  slide_pkg::beat_be_t  new_be;
  slide_pkg::byte_cnt_t in_room, out_room, step, copy_n;
  logic                 skip, go, last;

  assign rq_addr_o = vrf_pnt_q;
  assign rq_id_o   = issue_id_i;

  always_comb begin
    state_d   = state_q;
    in_pnt_d  = in_pnt_q;
    out_pnt_d = out_pnt_q;
    cnt_d     = cnt_q;
    vrf_pnt_d = vrf_pnt_q;
    acc_d     = acc_q;
    acc_be_d  = acc_be_q;

    operand_ready_o = 1'b0;
    issue_done_o    = 1'b0;
    rq_write_o      = 1'b0;
    rq_last_o       = 1'b0;

    // Bytes left in the operand and in the result beat
    in_room  = slide_pkg::byte_cnt_t'(slide_pkg::beat_bytes) - in_pnt_q;
    out_room = slide_pkg::byte_cnt_t'(slide_pkg::beat_bytes) - out_pnt_q;
    step     = (in_room < out_room) ? in_room : out_room;
    copy_n   = (cnt_q < step) ? cnt_q : step;
    last     = (cnt_q <= step);

    // Slide-down with a large offset drops whole leading beats
    skip = (state_q == st_run) && (in_pnt_q >= slide_pkg::beat_bytes);
    go   = (state_q == st_run) && !skip && operand_valid_i && !rq_full_i;

    // Line up the source bytes with the output pointer
    shifted = (operand_i >> (8 * in_pnt_q)) << (8 * out_pnt_q);
    new_be  = ~(slide_pkg::beat_be_t'('1) << copy_n);
    new_be  = new_be << out_pnt_q;

    // Merge the new bytes into the partial beat
    rq_be_o = acc_be_q | new_be;
    for (int b = 0; b < slide_pkg::beat_bytes; b++) begin
      rq_beat_o.bytes[b] = new_be[b] ? shifted.bytes[b] : acc_q.bytes[b];
    end

    unique case (state_q)
      st_idle: begin
        if (issue_valid_i) begin
          state_d   = st_run;
          acc_be_d  = '0;
          cnt_d     = issue_len_i - issue_offset_i;
          vrf_pnt_d = slide_pkg::vaddr_t'(issue_vd_i * slide_pkg::beats_per_reg);
          if (issue_op_i == slide_pkg::op_slideup) begin
            // Read from byte 0, write from the offset onwards
            in_pnt_d  = '0;
            out_pnt_d = slide_pkg::byte_cnt_t'(issue_offset_i % slide_pkg::beat_bytes);
            vrf_pnt_d = vrf_pnt_d
                      + slide_pkg::vaddr_t'(issue_offset_i / slide_pkg::beat_bytes);
          end else begin
            // Read from the offset, write from byte 0
            in_pnt_d  = issue_offset_i;
            out_pnt_d = '0;
          end
        end
      end
      st_run: begin
        if (skip) begin
          if (operand_valid_i) begin
            operand_ready_o = 1'b1;
            in_pnt_d        = in_pnt_q - slide_pkg::byte_cnt_t'(slide_pkg::beat_bytes);
          end
        end else if (go) begin
          in_pnt_d  = in_pnt_q + step;
          out_pnt_d = out_pnt_q + step;
          cnt_d     = cnt_q - copy_n;
          acc_d     = rq_beat_o;
          acc_be_d  = rq_be_o;
          // Operand used up
          if (last || in_pnt_d == slide_pkg::beat_bytes) begin
            in_pnt_d        = '0;
            operand_ready_o = 1'b1;
          end
          // Result beat complete
          if (last || out_pnt_d == slide_pkg::beat_bytes) begin
            out_pnt_d  = '0;
            rq_write_o = 1'b1;
            acc_be_d   = '0;
            vrf_pnt_d  = vrf_pnt_q + 1'b1;
          end
          if (last) begin
            state_d      = st_idle;
            issue_done_o = 1'b1;
            rq_last_o    = 1'b1;
          end
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= st_idle;
      in_pnt_q  <= '0;
      out_pnt_q <= '0;
      cnt_q     <= '0;
      vrf_pnt_q <= '0;
      acc_be_q  <= '0;
    end else begin
      state_q   <= state_d;
      in_pnt_q  <= in_pnt_d;
      out_pnt_q <= out_pnt_d;
      cnt_q     <= cnt_d;
      vrf_pnt_q <= vrf_pnt_d;
      acc_be_q  <= acc_be_d;
    end
  end

  // Partial beat data
  always_ff @(posedge clk_i) begin
    acc_q <= acc_d;
  end

  a_no_write_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rq_write_o |-> !rq_full_i);

  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {st_idle, st_run});

endmodule

// File: slide_insn_queue.sv
// Slide instruction queue
// Two-entry circular buffer with accept, issue and commit pointers.
// Converts length and offset to bytes and reports completion in order
`timescale 1ns/1ps

module slide_insn_queue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Sequencer request
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  slide_pkg::slide_op_e req_op_i,
  input  slide_pkg::sew_e      req_sew_i,
  input  slide_pkg::vl_t       req_vl_i,
  input  slide_pkg::vl_t       req_offset_i,
  input  slide_pkg::vreg_t     req_vd_i,
  input  slide_pkg::insn_id_t  req_id_i,
  // Issue side towards the engine
  output logic                 issue_valid_o,
  output slide_pkg::slide_op_e issue_op_o,
  output slide_pkg::sew_e      issue_sew_o,
  output slide_pkg::byte_cnt_t issue_len_o,
  output slide_pkg::byte_cnt_t issue_offset_o,
  output slide_pkg::vreg_t     issue_vd_o,
  output slide_pkg::insn_id_t  issue_id_o,
  input  logic                 issue_done_i,
  // Commit side from the result queue
  input  logic                 retire_last_i,
  output logic                 done_valid_o,
  output slide_pkg::insn_id_t  done_id_o
);

  // Stored instructions
  slide_pkg::slide_op_e op_q  [slide_pkg::insn_depth];
  slide_pkg::sew_e      sew_q [slide_pkg::insn_depth];
  slide_pkg::byte_cnt_t len_q [slide_pkg::insn_depth];
  slide_pkg::byte_cnt_t off_q [slide_pkg::insn_depth];
  slide_pkg::vreg_t     vd_q  [slide_pkg::insn_depth];
  slide_pkg::insn_id_t  id_q  [slide_pkg::insn_depth];

  // One pointer per phase
  logic [$clog2(slide_pkg::insn_depth)-1:0] accept_pnt_q;
  logic [$clog2(slide_pkg::insn_depth)-1:0] issue_pnt_q;
  logic [$clog2(slide_pkg::insn_depth)-1:0] commit_pnt_q;
  // Entries waiting to issue and to commit
  logic [$clog2(slide_pkg::insn_depth):0]   issue_cnt_q;
  logic [$clog2(slide_pkg::insn_depth):0]   commit_cnt_q;

  logic                accept;
  logic                done_valid_q;
  slide_pkg::insn_id_t done_id_q;

  // Full only counts entries not yet committed
  assign req_ready_o = (commit_cnt_q != slide_pkg::insn_depth);
  assign accept      = req_valid_i && req_ready_o;

  assign issue_valid_o  = (issue_cnt_q != '0);
  assign issue_op_o     = op_q[issue_pnt_q];
  assign issue_sew_o    = sew_q[issue_pnt_q];
  assign issue_len_o    = len_q[issue_pnt_q];
  assign issue_offset_o = off_q[issue_pnt_q];
  assign issue_vd_o     = vd_q[issue_pnt_q];
  assign issue_id_o     = id_q[issue_pnt_q];

  assign done_valid_o = done_valid_q;
  assign done_id_o    = done_id_q;

  // Entry storage and done id
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q[accept_pnt_q]  <= req_op_i;
      sew_q[accept_pnt_q] <= req_sew_i;
      // Elements to bytes
      len_q[accept_pnt_q] <= slide_pkg::byte_cnt_t'(req_vl_i) << req_sew_i;
      off_q[accept_pnt_q] <= slide_pkg::byte_cnt_t'(req_offset_i) << req_sew_i;
      vd_q[accept_pnt_q]  <= req_vd_i;
      id_q[accept_pnt_q]  <= req_id_i;
    end
    if (retire_last_i) begin
      done_id_q <= id_q[commit_pnt_q];
    end
  end

  // Pointers and counters
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      done_valid_q <= 1'b0;
    end else begin
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (issue_done_i) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
      end
      if (retire_last_i) begin
        commit_pnt_q <= commit_pnt_q + 1'b1;
      end
      issue_cnt_q  <= issue_cnt_q + accept - issue_done_i;
      commit_cnt_q <= commit_cnt_q + accept - retire_last_i;
      // One cycle after the last entry retired
      done_valid_q <= retire_last_i;
    end
  end

  // The result queue only retires beats of instructions held here
  a_retire_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    retire_last_i |-> (commit_cnt_q != '0));

  a_offset_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> (req_offset_i < req_vl_i));

endmodule

// File: slide_pkg.sv
// Slide unit shared definitions
// Sizes, operation encodings and the beat layout used by the
// instruction queue, the slide engine and the result queue
package slide_pkg;

  // Datapath geometry
  localparam int unsigned nr_lanes      = 4;
  localparam int unsigned lane_bytes    = 8;
  localparam int unsigned beat_bytes    = nr_lanes * lane_bytes;
  localparam int unsigned beats_per_reg = 8;

  // Queue depths
  localparam int unsigned insn_depth    = 2;
  localparam int unsigned result_depth  = 2;

  typedef logic [8*lane_bytes-1:0] lane_word_t;
  typedef logic [lane_bytes-1:0]   lane_be_t;

  // Byte count or byte offset inside one vector, up to 256
  typedef logic [8:0] byte_cnt_t;
  // Register times beats_per_reg plus beat index
  typedef logic [7:0] vaddr_t;
  typedef logic [2:0] insn_id_t;
  // Vector length or offset in elements, 0 to 32
  typedef logic [5:0] vl_t;
  // Vector register number
  typedef logic [4:0] vreg_t;

  // Encoded as log2 of the element size in bytes
  typedef enum logic [1:0] {
    ew8  = 2'd0,
    ew16 = 2'd1,
    ew32 = 2'd2,
    ew64 = 2'd3
  } sew_e;

  typedef enum logic {
    op_slideup   = 1'b0,
    op_slidedown = 1'b1
  } slide_op_e;

  // One beat across all lanes
  // Lanes see the word view, the engine moves bytes through the byte view
  typedef union packed {
    lane_word_t [nr_lanes-1:0]     word;
    logic [beat_bytes-1:0][7:0]    bytes;
  } beat_u;

  typedef logic [beat_bytes-1:0] beat_be_t;

endpackage

// File: slide_result_queue.sv
// Slide result queue
// Two-entry buffer of result beats with one request per lane.
// An entry retires once every lane has been granted
`timescale 1ns/1ps

module slide_result_queue (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // Write port from the engine
  input  logic                                         rq_write_i,
  input  slide_pkg::beat_u                             rq_beat_i,
  input  slide_pkg::beat_be_t                          rq_be_i,
  input  slide_pkg::vaddr_t                            rq_addr_i,
  input  slide_pkg::insn_id_t                          rq_id_i,
  input  logic                                         rq_last_i,
  output logic                                         rq_full_o,
  // Lane write port
  output logic                [slide_pkg::nr_lanes-1:0] result_req_o,
  output slide_pkg::vaddr_t                            result_addr_o,
  output slide_pkg::insn_id_t                          result_id_o,
  output slide_pkg::lane_word_t [slide_pkg::nr_lanes-1:0] result_wdata_o,
  output slide_pkg::lane_be_t [slide_pkg::nr_lanes-1:0] result_be_o,
  input  logic                [slide_pkg::nr_lanes-1:0] result_gnt_i,
  // Last beat of an instruction has left
  output logic                                         retire_last_o
);

  // Entry payload
  slide_pkg::beat_u     data_q [slide_pkg::result_depth];
  slide_pkg::beat_be_t  be_q   [slide_pkg::result_depth];
  slide_pkg::vaddr_t    addr_q [slide_pkg::result_depth];
  slide_pkg::insn_id_t  id_q   [slide_pkg::result_depth];
  logic                 last_q [slide_pkg::result_depth];

  // Pending lane requests per entry
  logic [slide_pkg::nr_lanes-1:0] valid_q [slide_pkg::result_depth];

  logic [$clog2(slide_pkg::result_depth)-1:0] wr_pnt_q, rd_pnt_q;
  logic [$clog2(slide_pkg::result_depth):0]   cnt_q;
  logic                                        retire;
  logic                                        retire_last_q;

  assign rq_full_o = (cnt_q == slide_pkg::result_depth);

  // Head entry drives the lanes
  assign result_req_o   = valid_q[rd_pnt_q];
  assign result_addr_o  = addr_q[rd_pnt_q];
  assign result_id_o    = id_q[rd_pnt_q];
  assign result_wdata_o = data_q[rd_pnt_q].word;
  // Byte b sits in lane b/8
  assign result_be_o    = be_q[rd_pnt_q];

  // No lane left pending after this cycle's grants
  assign retire = (cnt_q != '0) && ((valid_q[rd_pnt_q] & ~result_gnt_i) == '0);

  assign retire_last_o = retire_last_q;

  always_ff @(posedge clk_i) begin
    if (rq_write_i) begin
      data_q[wr_pnt_q] <= rq_beat_i;
      be_q[wr_pnt_q]   <= rq_be_i;
      addr_q[wr_pnt_q] <= rq_addr_i;
      id_q[wr_pnt_q]   <= rq_id_i;
      last_q[wr_pnt_q] <= rq_last_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q       <= '{default: '0};
      wr_pnt_q      <= '0;
      rd_pnt_q      <= '0;
      cnt_q         <= '0;
      retire_last_q <= 1'b0;
    end else begin
      // Granted lanes drop their request
      valid_q[rd_pnt_q] <= valid_q[rd_pnt_q] & ~result_gnt_i;
      // A new entry requests on every lane
      if (rq_write_i) begin
        valid_q[wr_pnt_q] <= '1;
        wr_pnt_q          <= wr_pnt_q + 1'b1;
      end
      if (retire) begin
        rd_pnt_q <= rd_pnt_q + 1'b1;
      end
      cnt_q         <= cnt_q + rq_write_i - retire;
      retire_last_q <= retire && last_q[rd_pnt_q];
    end
  end

  a_gnt_with_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (result_gnt_i & ~result_req_o) == '0);

endmodule

// File: slide_unit.f
slide_pkg.sv
slide_insn_queue.sv
slide_engine.sv
slide_result_queue.sv
slide_unit.sv
tb_slide_unit.sv

// File: slide_unit.sv
// Vector slide unit top level
// Instruction queue, slide engine and result queue for a four-lane
// vector machine
`timescale 1ns/1ps

module slide_unit (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  // Sequencer requests
  input  logic                                           req_valid_i,
  output logic                                           req_ready_o,
  input  slide_pkg::slide_op_e                           req_op_i,
  input  slide_pkg::sew_e                                req_sew_i,
  input  slide_pkg::vl_t                                 req_vl_i,
  input  slide_pkg::vl_t                                 req_offset_i,
  input  slide_pkg::vreg_t                               req_vd_i,
  input  slide_pkg::insn_id_t                            req_id_i,
  // Source operand beats
  input  slide_pkg::beat_u                               operand_i,
  input  logic                                           operand_valid_i,
  output logic                                           operand_ready_o,
  // Lane writes
  output logic                 [slide_pkg::nr_lanes-1:0] result_req_o,
  output slide_pkg::vaddr_t                              result_addr_o,
  output slide_pkg::insn_id_t                            result_id_o,
  output slide_pkg::lane_word_t [slide_pkg::nr_lanes-1:0] result_wdata_o,
  output slide_pkg::lane_be_t  [slide_pkg::nr_lanes-1:0] result_be_o,
  input  logic                 [slide_pkg::nr_lanes-1:0] result_gnt_i,
  // Completion
  output logic                                           done_valid_o,
  output slide_pkg::insn_id_t                            done_id_o
);

  // Issue instruction
  logic                 issue_valid;
  slide_pkg::slide_op_e issue_op;
  slide_pkg::sew_e      issue_sew;
  slide_pkg::byte_cnt_t issue_len;
  slide_pkg::byte_cnt_t issue_offset;
  slide_pkg::vreg_t     issue_vd;
  slide_pkg::insn_id_t  issue_id;
  logic                 issue_done;

  // Engine to result queue
  logic                 rq_write;
  slide_pkg::beat_u     rq_beat;
  slide_pkg::beat_be_t  rq_be;
  slide_pkg::vaddr_t    rq_addr;
  slide_pkg::insn_id_t  rq_id;
  logic                 rq_last;
  logic                 rq_full;
  logic                 retire_last;

  slide_insn_queue u_insn_queue (
    .clk_i, .rst_ni,
    .req_valid_i, .req_ready_o, .req_op_i, .req_sew_i,
    .req_vl_i, .req_offset_i, .req_vd_i, .req_id_i,
    .issue_valid_o  (issue_valid),
    .issue_op_o     (issue_op),
    .issue_sew_o    (issue_sew),
    .issue_len_o    (issue_len),
    .issue_offset_o (issue_offset),
    .issue_vd_o     (issue_vd),
    .issue_id_o     (issue_id),
    .issue_done_i   (issue_done),
    .retire_last_i  (retire_last),
    .done_valid_o, .done_id_o
  );

  slide_engine u_engine (
    .clk_i, .rst_ni,
    .issue_valid_i  (issue_valid),
    .issue_op_i     (issue_op),
    .issue_sew_i    (issue_sew),
    .issue_len_i    (issue_len),
    .issue_offset_i (issue_offset),
    .issue_vd_i     (issue_vd),
    .issue_id_i     (issue_id),
    .issue_done_o   (issue_done),
    .operand_i, .operand_valid_i, .operand_ready_o,
    .rq_full_i      (rq_full),
    .rq_write_o     (rq_write),
    .rq_beat_o      (rq_beat),
    .rq_be_o        (rq_be),
    .rq_addr_o      (rq_addr),
    .rq_id_o        (rq_id),
    .rq_last_o      (rq_last)
  );

  slide_result_queue u_result_queue (
    .clk_i, .rst_ni,
    .rq_write_i     (rq_write),
    .rq_beat_i      (rq_beat),
    .rq_be_i        (rq_be),
    .rq_addr_i      (rq_addr),
    .rq_id_i        (rq_id),
    .rq_last_i      (rq_last),
    .rq_full_o      (rq_full),
    .result_req_o, .result_addr_o, .result_id_o,
    .result_wdata_o, .result_be_o, .result_gnt_i,
    .retire_last_o  (retire_last)
  );

endmodule

// File: tb_slide_unit.sv
// Slide unit testbench
// Drives slide instructions, models the operand lanes and the lane grants,
// and checks results, enables, completion order and back-pressure
`timescale 1ns/1ps

module tb_slide_unit;

  localparam int n_insn = 12;
  localparam int cycle_limit = 40 * n_insn + 100;

  logic clk_i = 1'b0;
  logic rst_ni;

  logic                 req_valid_i;
  logic                 req_ready_o;
  slide_pkg::slide_op_e req_op_i;
  slide_pkg::sew_e      req_sew_i;
  slide_pkg::vl_t       req_vl_i;
  slide_pkg::vl_t       req_offset_i;
  slide_pkg::vreg_t     req_vd_i;
  slide_pkg::insn_id_t  req_id_i;
  slide_pkg::beat_u     operand_i;
  logic                 operand_valid_i;
  logic                 operand_ready_o;
  logic                 [slide_pkg::nr_lanes-1:0] result_req_o;
  slide_pkg::vaddr_t    result_addr_o;
  slide_pkg::insn_id_t  result_id_o;
  slide_pkg::lane_word_t [slide_pkg::nr_lanes-1:0] result_wdata_o;
  slide_pkg::lane_be_t  [slide_pkg::nr_lanes-1:0] result_be_o;
  logic                 [slide_pkg::nr_lanes-1:0] result_gnt_i;
  logic                 done_valid_o;
  slide_pkg::insn_id_t  done_id_o;

  // Instruction model, indexed by id
  logic m_up [8];
  int   m_len [8];
  int   m_off [8];
  int   m_vd [8];
  int   m_in_beats [8];
  int   m_out_beats [8];
  int   m_done_beats [8];

  // Ids waiting for completion and for operands
  int   acc_q [$];
  int   opnd_q [$];
  int   beat_idx;
  logic beat_taken;
  int   outstanding;
  int   exp_done_id;
  int   acc_cnt;
  int   done_cnt;
  int   errors;
  int   cycles;
  int   tests;
  int   stall_cycles;
  logic hold_grants;
  logic check_idle;
  slide_pkg::insn_id_t next_id;

  slide_unit u_slide_unit (.*);

  always #4 clk_i = ~clk_i;

  // Source vector byte i of instruction id
  function automatic logic [7:0] src_byte(int id, int i);
    return 8'(i * 7 + id);
  endfunction

  // Bytes of a lane word that the slide rule lets the unit write
  function automatic slide_pkg::lane_be_t allowed_be(int id, int addr, int lane);
    slide_pkg::lane_be_t be;
    int j;
    be = '0;
    for (int k = 0; k < slide_pkg::lane_bytes; k++) begin
      j = (addr - m_vd[id] * 8) * slide_pkg::beat_bytes + lane * slide_pkg::lane_bytes + k;
      if (m_up[id]) begin
        be[k] = (j >= m_off[id]) && (j < m_len[id]);
      end else begin
        be[k] = (j >= 0) && (j < m_len[id] - m_off[id]);
      end
    end
    return be;
  endfunction

  // Expected lane word, zero where nothing may be written
  function automatic slide_pkg::lane_word_t exp_word(int id, int addr, int lane);
    slide_pkg::lane_word_t w;
    slide_pkg::lane_be_t ok;
    int j;
    w  = '0;
    ok = allowed_be(id, addr, lane);
    for (int k = 0; k < slide_pkg::lane_bytes; k++) begin
      j = (addr - m_vd[id] * 8) * slide_pkg::beat_bytes + lane * slide_pkg::lane_bytes + k;
      if (ok[k]) begin
        w[8*k +: 8] = m_up[id] ? src_byte(id, j - m_off[id]) : src_byte(id, j + m_off[id]);
      end
    end
    return w;
  endfunction

  function automatic slide_pkg::lane_word_t be_mask(slide_pkg::lane_be_t be);
    slide_pkg::lane_word_t m;
    for (int k = 0; k < slide_pkg::lane_bytes; k++) begin
      m[8*k +: 8] = {8{be[k]}};
    end
    return m;
  endfunction

  // Per lane data, enable and stability checks
  for (genvar l = 0; l < slide_pkg::nr_lanes; l++) begin : g_lane
    a_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_req_o[l] && result_gnt_i[l] |->
        (result_wdata_o[l] & be_mask(result_be_o[l])) ==
        (exp_word(result_id_o, result_addr_o, l) & be_mask(result_be_o[l])))
    else begin
      errors++;
      $display("error result_wdata_o[%0d] got %h expected %h", l,
               $sampled(result_wdata_o[l]) & be_mask($sampled(result_be_o[l])),
               exp_word($sampled(result_id_o), $sampled(result_addr_o), l)
                 & be_mask($sampled(result_be_o[l])));
    end

    a_be: assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_req_o[l] |->
        (result_be_o[l] & ~allowed_be(result_id_o, result_addr_o, l)) == '0)
    else begin
      errors++;
      $display("error result_be_o[%0d] got %h allowed %h", l, $sampled(result_be_o[l]),
               allowed_be($sampled(result_id_o), $sampled(result_addr_o), l));
    end

    // Ungranted request holds with its payload
    a_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_req_o[l] && !result_gnt_i[l] |=>
        result_req_o[l] && $stable(result_wdata_o[l]) && $stable(result_be_o[l])
        && $stable(result_addr_o))
    else begin
      errors++;
      $display("error result_req_o[%0d] payload changed before grant, req %h addr %h",
               l, result_req_o, result_addr_o);
    end
  end

  // A done pulse needs an accepted instruction still waiting for it
  a_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_valid_o |-> outstanding > 0 && done_id_o == exp_done_id
                     && m_done_beats[done_id_o] == m_out_beats[done_id_o])
  else begin
    errors++;
    $display("error done_id_o got %h expected %h, pending %h, beats granted %h of %h",
             $sampled(done_id_o), $sampled(exp_done_id), $sampled(outstanding),
             m_done_beats[$sampled(done_id_o)], m_out_beats[$sampled(done_id_o)]);
  end

  a_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_ready_o == (outstanding < 2 || done_valid_o))
  else begin
    errors++;
    $display("error req_ready_o got %h expected %h", $sampled(req_ready_o),
             $sampled(outstanding) < 2 || $sampled(done_valid_o));
  end

  a_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_cycles > 20 |-> !operand_ready_o)
  else begin
    errors++;
    $display("error operand_ready_o got %h expected %h", 1'b1, 1'b0);
  end

  a_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    check_idle |-> req_ready_o && !operand_ready_o && result_req_o == '0 && !done_valid_o)
  else begin
    errors++;
    $display("error reset state req_ready_o %h operand_ready_o %h result_req_o %h done %h",
             $sampled(req_ready_o), $sampled(operand_ready_o), $sampled(result_req_o),
             $sampled(done_valid_o));
  end

  // Model updates on each rising edge
  always @(posedge clk_i) begin
    int id;
    if (rst_ni) begin
      if (req_valid_i && req_ready_o) begin
        id = req_id_i;
        m_up[id]  = (req_op_i == slide_pkg::op_slideup);
        m_len[id] = int'(req_vl_i) << req_sew_i;
        m_off[id] = int'(req_offset_i) << req_sew_i;
        m_vd[id]  = req_vd_i;
        m_done_beats[id] = 0;
        if (m_up[id]) begin
          m_in_beats[id]  = (m_len[id] - m_off[id] + 31) / 32;
          m_out_beats[id] = (m_off[id] % 32 + m_len[id] - m_off[id] + 31) / 32;
        end else begin
          m_in_beats[id]  = (m_len[id] + 31) / 32;
          m_out_beats[id] = (m_len[id] - m_off[id] + 31) / 32;
        end
        acc_q.push_back(id);
        opnd_q.push_back(id);
        acc_cnt++;
      end
      if (operand_valid_i && operand_ready_o) begin
        beat_taken = 1'b1;
        beat_idx++;
        if (beat_idx == m_in_beats[opnd_q[0]]) begin
          void'(opnd_q.pop_front());
          beat_idx = 0;
        end
      end
      // Entry retires once no lane is left waiting
      if (result_req_o != '0 && (result_req_o & ~result_gnt_i) == '0) begin
        m_done_beats[result_id_o]++;
      end
      if (done_valid_o) begin
        void'(acc_q.pop_front());
        done_cnt++;
      end
      if (acc_q.size() > 0) begin
        exp_done_id = acc_q[0];
      end
      outstanding  = acc_q.size();
      stall_cycles = hold_grants ? stall_cycles + 1 : 0;
    end
  end

  // Operand lanes and lane grants, driven on the falling edge
  initial begin
    void'($urandom(53));
    forever begin
      @(negedge clk_i);
      if (rst_ni) begin
        if (beat_taken) begin
          operand_valid_i = 1'b0;
          beat_taken      = 1'b0;
        end
        if (!operand_valid_i && opnd_q.size() > 0 && $urandom % 4 != 0) begin
          for (int k = 0; k < slide_pkg::beat_bytes; k++) begin
            operand_i.bytes[k] = src_byte(opnd_q[0], beat_idx * slide_pkg::beat_bytes + k);
          end
          operand_valid_i = 1'b1;
        end
        for (int l = 0; l < slide_pkg::nr_lanes; l++) begin
          result_gnt_i[l] = result_req_o[l] && !hold_grants && ($urandom % 3 != 0);
        end
      end
    end
  end

  // Watchdog
  always @(posedge clk_i) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, %0d of %0d instructions done",
               cycles, done_cnt, acc_cnt);
      $display("Test failures found");
      $finish;
    end
  end

  // Hands one instruction over and returns the cycles it was held off
  task automatic send(input slide_pkg::slide_op_e op, input slide_pkg::sew_e sew,
                      input int vl, input int off, input int vd, output int held);
    held = 0;
    @(negedge clk_i);
    req_valid_i  = 1'b1;
    req_op_i     = op;
    req_sew_i    = sew;
    req_vl_i     = slide_pkg::vl_t'(vl);
    req_offset_i = slide_pkg::vl_t'(off);
    req_vd_i     = slide_pkg::vreg_t'(vd);
    req_id_i     = next_id;
    @(posedge clk_i);
    while (!req_ready_o) begin
      held++;
      @(posedge clk_i);
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
    next_id     = next_id + 1'b1;
  endtask

  task automatic wait_all_done(input string name);
    while (done_cnt != acc_cnt) begin
      @(posedge clk_i);
    end
    tests++;
    $display("test %s finished, failed checks so far %0d", name, errors);
  endtask

  // Slide-up and slide-down at one element width
  task automatic run_width(input slide_pkg::sew_e sew, input int vl_up, input int off_up,
                           input int vl_dn, input int off_dn, input int vd);
    int held;
    send(slide_pkg::op_slideup, sew, vl_up, off_up, vd, held);
    send(slide_pkg::op_slidedown, sew, vl_dn, off_dn, vd + 1, held);
  endtask

  initial begin
    int held;
    rst_ni          = 1'b0;
    req_valid_i     = 1'b0;
    req_op_i        = slide_pkg::op_slideup;
    req_sew_i       = slide_pkg::ew8;
    req_vl_i        = '0;
    req_offset_i    = '0;
    req_vd_i        = '0;
    req_id_i        = '0;
    operand_i       = '0;
    operand_valid_i = 1'b0;
    result_gnt_i    = '0;
    beat_idx    = 0;
    beat_taken  = 1'b0;
    outstanding = 0;
    exp_done_id = 0;
    acc_cnt     = 0;
    done_cnt    = 0;
    errors      = 0;
    cycles      = 0;
    tests       = 0;
    stall_cycles = 0;
    hold_grants = 1'b0;
    check_idle  = 1'b0;
    next_id     = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni     = 1'b1;
    check_idle = 1'b1;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_idle = 1'b0;
    tests++;
    $display("test reset state finished, failed checks so far %0d", errors);

    // Both slides of a width go in back to back
    run_width(slide_pkg::ew8, 32, 5, 30, 3, 1);
    wait_all_done("ew8 slides");
    run_width(slide_pkg::ew16, 20, 7, 32, 9, 3);
    wait_all_done("ew16 slides");
    run_width(slide_pkg::ew32, 24, 10, 32, 20, 5);
    wait_all_done("ew32 slides");
    run_width(slide_pkg::ew64, 32, 13, 12, 5, 7);
    wait_all_done("ew64 slides");

    // Withheld grants fill the result queue
    hold_grants = 1'b1;
    send(slide_pkg::op_slideup, slide_pkg::ew64, 16, 0, 9, held);
    repeat (30) @(posedge clk_i);
    @(negedge clk_i);
    hold_grants = 1'b0;
    wait_all_done("grant back-pressure");

    // Third request waits for a free instruction slot
    hold_grants = 1'b1;
    send(slide_pkg::op_slideup, slide_pkg::ew8, 16, 2, 10, held);
    send(slide_pkg::op_slidedown, slide_pkg::ew8, 16, 2, 11, held);
    fork
      begin
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        hold_grants = 1'b0;
      end
      send(slide_pkg::op_slideup, slide_pkg::ew16, 8, 1, 12, held);
    join
    if (held == 0) begin
      errors++;
      $display("third request was accepted while two instructions were pending");
    end
    wait_all_done("full instruction queue");

    $display("tests %0d, instructions %0d, failed checks %0d", tests, done_cnt, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
